/* logic/vp_pkg.sv */
`default_nettype none

package vp_pkg;

	////////////////////////////////
	// Widths
	////////////////////////////////
	localparam int ROM_AW = 13;
	localparam int CART_AW = 12;
	localparam int DATA_W = 8;
	localparam int SIZE_W = 16;
	localparam int DIV_W = 4;
	localparam int RGB_W = 24;
	localparam int NUMPAD_W = 10;

	// Size thresholds enabling bank lines 0 and 1
	localparam logic [SIZE_W-1:0] BANK0_SIZE = 16'd4096;
	localparam logic [SIZE_W-1:0] BANK1_SIZE = 16'd8192;

	// Enable periods in system clocks
	localparam logic [DIV_W-1:0] CPU_DIV_NTSC = 4'd8;
	localparam logic [DIV_W-1:0] CPU_DIV_PAL = 4'd12;
	localparam logic [DIV_W-1:0] VDC_DIV_NTSC = 4'd6;
	localparam logic [DIV_W-1:0] VDC_DIV_PAL = 4'd10;

	// Open bus value on the cartridge slot
	localparam logic [DATA_W-1:0] EMPTY_BYTE = 8'hFF;

	////////////////////////////////
	// Keyboard
	////////////////////////////////
	typedef struct packed {
		logic toggle;
		logic pressed;
		logic extended;
		logic [7:0] code;
	} key_event_t;

	// Set-2 codes of digits 0 to 9
	localparam logic [7:0] DIGIT_CODES [10] = '{
		8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D, 8'h3E, 8'h46
	};

	// Set-2 codes of letters a to z
	localparam logic [7:0] LETTER_CODES [26] = '{
		8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B, 8'h34, 8'h33, 8'h43,
		8'h3B, 8'h42, 8'h4B, 8'h3A, 8'h31, 8'h44, 8'h4D, 8'h15, 8'h2D,
		8'h1B, 8'h2C, 8'h3C, 8'h2A, 8'h1D, 8'h22, 8'h35, 8'h1A
	};

	typedef logic [255:0][7:0] ascii_table_t;

	function automatic ascii_table_t build_scan_ascii();
		ascii_table_t t;
		t = '0;
		for (int i = 0; i < 10; i++) begin
			t[DIGIT_CODES[i]] = 8'("0" + i);
		end
		for (int i = 0; i < 26; i++) begin
			t[LETTER_CODES[i]] = 8'("a" + i);
		end
		t[8'h29] = " ";
		t[8'h79] = "+";
		t[8'h7B] = "-";
		t[8'h7C] = "*";
		t[8'h4A] = "/";
		t[8'h55] = "=";
		// GUI keys act as yes and no
		t[8'h1F] = 8'h11;
		t[8'h27] = 8'h12;
		// Enter and backspace
		t[8'h5A] = 8'h0A;
		t[8'h66] = 8'h08;
		return t;
	endfunction

	// Unlisted codes stay at 0x00
	localparam ascii_table_t SCAN_ASCII = build_scan_ascii();

	////////////////////////////////
	// Video colour
	////////////////////////////////
	typedef struct packed {
		logic r;
		logic g;
		logic b;
		logic luma;
	} colour_bits_t;

	typedef union packed {
		logic [3:0] index;
		colour_bits_t bits;
	} colour_code_u;

	// Calibrated palette, four entries per line
	localparam logic [RGB_W-1:0] PALETTE_NTSC [16] = '{
		24'h000000, 24'h676767, 24'h1A37BE, 24'h5C80F6,
		24'h006D07, 24'h56C469, 24'h2AAABE, 24'h77E6EB,
		24'h790000, 24'hC75151, 24'h94309F, 24'hDC84E8,
		24'h77670B, 24'hC6B86A, 24'hCECECE, 24'hFFFFFF
	};

	localparam logic [RGB_W-1:0] PALETTE_PAL [16] = '{
		24'h000000, 24'h494949, 24'h0000B6, 24'h4949FF,
		24'h00B601, 24'h49FF49, 24'h00B6C9, 24'h49FFFF,
		24'hB60000, 24'hFF4949, 24'hB600B6, 24'hFF49FF,
		24'hB6B600, 24'hFFFF49, 24'hB6B6B6, 24'hFFFFFF
	};

endpackage

`default_nettype wire

/* logic/rom_port_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One requester of the cartridge ROM
interface rom_port_if;
	logic [vp_pkg::ROM_AW-1:0] addr;
	logic [vp_pkg::DATA_W-1:0] wdata;
	logic we;
	logic re;
	// Valid one cycle after a granted read
	logic [vp_pkg::DATA_W-1:0] rdata;

	modport requester (output addr, output wdata, output we, output re, input rdata);

	modport arbiter (input addr, input wdata, input we, input re, output rdata);

endinterface

`default_nettype wire

/* logic/clock_enable_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_enable_gen (
	input  logic clk_sys,
	input  logic reset,
	input  logic is_pal_i,
	output logic cpu_en_o,
	output logic vdc_en_o
);

	// Channel 0 is the CPU, channel 1 the VDC
	logic [vp_pkg::DIV_W-1:0] end_cnt [2];
	logic [vp_pkg::DIV_W-1:0] cnt_q [2];
	logic [1:0] pulse_q;

	// Last count of the period for the selected standard
	always_comb begin
		end_cnt[0] = (is_pal_i ? vp_pkg::CPU_DIV_PAL : vp_pkg::CPU_DIV_NTSC) - 1'b1;
		end_cnt[1] = (is_pal_i ? vp_pkg::VDC_DIV_PAL : vp_pkg::VDC_DIV_NTSC) - 1'b1;
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cnt_q <= '{default: '0};
			pulse_q <= '0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				// Greater-or-equal also wraps when the period shrinks
				if (cnt_q[i] >= end_cnt[i]) begin
					cnt_q[i] <= '0;
					pulse_q[i] <= 1'b1;
				end else begin
					cnt_q[i] <= cnt_q[i] + 1'b1;
					pulse_q[i] <= 1'b0;
				end
			end
		end
	end

	assign cpu_en_o = pulse_q[0];
	assign vdc_en_o = pulse_q[1];

endmodule

`default_nettype wire

/* logic/cart_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_loader (
	input  logic clk_sys,
	input  logic reset,
	input  logic dl_active_i,
	input  logic dl_wr_i,
	input  logic [vp_pkg::DATA_W-1:0] dl_data_i,
	rom_port_if.requester load_port,
	output logic [vp_pkg::SIZE_W-1:0] cart_size_o
);

	logic dl_active_q;
	logic dl_start;
	logic [vp_pkg::SIZE_W-1:0] count_q;
	logic [vp_pkg::SIZE_W-1:0] base;

	// Rising edge of the download flag
	assign dl_start = dl_active_i & ~dl_active_q;

	// A write in the start cycle already lands at zero
	assign base = dl_start ? '0 : count_q;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dl_active_q <= 1'b0;
			count_q <= '0;
		end else begin
			dl_active_q <= dl_active_i;
			count_q <= base + {{(vp_pkg::SIZE_W-1){1'b0}}, load_port.we};
		end
	end

	// Byte count doubles as write address
	assign load_port.we = dl_active_i & dl_wr_i;
	assign load_port.addr = base[vp_pkg::ROM_AW-1:0];
	assign load_port.wdata = dl_data_i;
	// Write-only requester
	assign load_port.re = 1'b0;

	assign cart_size_o = count_q;

endmodule

`default_nettype wire

/* logic/cart_bank_map.sv */
`timescale 1ns/1ps
`default_nettype none

module cart_bank_map (
	input  logic [vp_pkg::CART_AW-1:0] cart_addr_i,
	input  logic cart_bs0_i,
	input  logic cart_bs1_i,
	input  logic cart_psen_n_i,
	input  logic [vp_pkg::SIZE_W-1:0] cart_size_i,
	rom_port_if.requester read_port
);

	logic bank0;
	logic bank1;

	// Bank lines only count when the image is big enough
	assign bank0 = cart_bs0_i & (cart_size_i >= vp_pkg::BANK0_SIZE);
	assign bank1 = cart_bs1_i & (cart_size_i >= vp_pkg::BANK1_SIZE);

	// Address bit 10 is not decoded by the slot
	assign read_port.addr = {bank1, bank0, cart_addr_i[11], cart_addr_i[9:0]};

	// Program store enable is the read strobe
	assign read_port.re = ~cart_psen_n_i;

	// Read-only requester
	assign read_port.we = 1'b0;
	assign read_port.wdata = '0;

endmodule

`default_nettype wire

/* logic/rom_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module rom_arbiter (
	input  logic clk_sys,
	input  logic reset,
	input  logic dl_active_i,
	rom_port_if.arbiter load_port,
	rom_port_if.arbiter read_port,
	output logic [vp_pkg::DATA_W-1:0] cart_data_o
);

	logic [vp_pkg::DATA_W-1:0] mem [2**vp_pkg::ROM_AW];
	logic rd_grant;
	logic rd_valid_q;
	logic [vp_pkg::DATA_W-1:0] rd_byte_q;

	////////////////////////////////
	// Grant
	////////////////////////////////
	// Loader wins, reader locked out during download
	assign rd_grant = read_port.re & ~load_port.we & ~dl_active_i;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			rd_valid_q <= 1'b0;
		end else begin
			rd_valid_q <= rd_grant;
		end
	end

	////////////////////////////////
	// Array
	////////////////////////////////
	always_ff @(posedge clk_sys) begin
		if (load_port.we) begin
			mem[load_port.addr] <= load_port.wdata;
		end
		if (rd_grant) begin
			rd_byte_q <= mem[read_port.addr];
		end
	end

	// Open bus unless the last read was granted
	assign read_port.rdata = rd_valid_q ? rd_byte_q : vp_pkg::EMPTY_BYTE;

	// Loader has no read path
	assign load_port.rdata = vp_pkg::EMPTY_BYTE;

	assign cart_data_o = read_port.rdata;

endmodule

`default_nettype wire

/* logic/key_translator.sv */
`timescale 1ns/1ps
`default_nettype none

module key_translator (
	input  logic clk_sys,
	input  logic reset,
	input  vp_pkg::key_event_t key_event_i,
	input  logic [vp_pkg::NUMPAD_W-1:0] joy_numpad_i,
	output logic kbd_ready_o,
	output logic [7:0] kbd_ascii_o,
	output logic kbd_released_o
);

	logic toggle_q;
	logic [vp_pkg::NUMPAD_W-1:0] numpad_q;
	logic key_chg;
	logic pad_chg;

	// Lowest set button wins
	function automatic logic [7:0] numpad_ascii(input logic [vp_pkg::NUMPAD_W-1:0] pad);
		logic [7:0] ascii;
		ascii = 8'h00;
		for (int i = vp_pkg::NUMPAD_W - 1; i >= 0; i--) begin
			if (pad[i]) begin
				// Top button is the zero key
				ascii = (i == 9) ? "0" : 8'("1" + i);
			end
		end
		return ascii;
	endfunction

	////////////////////////////////
	// Change detect
	////////////////////////////////
	assign key_chg = key_event_i.toggle != toggle_q;
	assign pad_chg = joy_numpad_i != numpad_q;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			toggle_q <= 1'b0;
			numpad_q <= '0;
		end else begin
			toggle_q <= key_event_i.toggle;
			numpad_q <= joy_numpad_i;
		end
	end

	////////////////////////////////
	// Key event out
	////////////////////////////////
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			kbd_ready_o <= 1'b0;
			kbd_ascii_o <= 8'h00;
			kbd_released_o <= 1'b0;
		end else begin
			// One-cycle strobe on either source
			kbd_ready_o <= key_chg | pad_chg;
			if (key_chg) begin
				// Scan code beats the numpad
				kbd_ascii_o <= vp_pkg::SCAN_ASCII[key_event_i.code];
			end else if (pad_chg) begin
				kbd_ascii_o <= numpad_ascii(joy_numpad_i);
			end
			if (key_chg | pad_chg) begin
				// Held numpad button keeps the key down
				kbd_released_o <= ~key_event_i.pressed & ~(|joy_numpad_i);
			end
		end
	end

endmodule

`default_nettype wire

/* logic/palette_lut.sv */
`timescale 1ns/1ps
`default_nettype none

module palette_lut (
	input  logic clk_sys,
	input  logic reset,
	input  logic is_pal_i,
	input  vp_pkg::colour_code_u colour_i,
	output logic [vp_pkg::RGB_W-1:0] rgb_o
);

	// One cycle from colour code to pixel
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			rgb_o <= '0;
		end else if (is_pal_i) begin
			rgb_o <= vp_pkg::PALETTE_PAL[colour_i.index];
		end else begin
			rgb_o <= vp_pkg::PALETTE_NTSC[colour_i.index];
		end
	end

endmodule

`default_nettype wire

/* logic/vp_glue_top.sv */
`timescale 1ns/1ps
`default_nettype none

module vp_glue_top (
	input  logic clk_sys,
	input  logic reset,
	input  logic is_pal_i,
	input  logic dl_active_i,
	input  logic dl_wr_i,
	input  logic [vp_pkg::DATA_W-1:0] dl_data_i,
	input  logic [vp_pkg::CART_AW-1:0] cart_addr_i,
	input  logic cart_bs0_i,
	input  logic cart_bs1_i,
	input  logic cart_psen_n_i,
	input  logic [$bits(vp_pkg::key_event_t)-1:0] key_event_i,
	input  logic [vp_pkg::NUMPAD_W-1:0] joy_numpad_i,
	input  logic [3:0] colour_i,
	output logic cpu_en_o,
	output logic vdc_en_o,
	output logic [vp_pkg::DATA_W-1:0] cart_data_o,
	output logic kbd_ready_o,
	output logic [7:0] kbd_ascii_o,
	output logic kbd_released_o,
	output logic [vp_pkg::RGB_W-1:0] rgb_o
);

	logic [vp_pkg::SIZE_W-1:0] cart_size;
	vp_pkg::colour_code_u colour_code;

	rom_port_if load_port ();
	rom_port_if read_port ();

	// Console drives R, G, B, luma as separate lines
	assign colour_code.bits.r = colour_i[3];
	assign colour_code.bits.g = colour_i[2];
	assign colour_code.bits.b = colour_i[1];
	assign colour_code.bits.luma = colour_i[0];

	////////////////////////////////
	// Clocking
	////////////////////////////////
	clock_enable_gen u_clk_en (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.is_pal_i (is_pal_i),
		.cpu_en_o (cpu_en_o),
		.vdc_en_o (vdc_en_o)
	);

	////////////////////////////////
	// Cartridge
	////////////////////////////////
	cart_loader u_loader (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_active_i (dl_active_i),
		.dl_wr_i     (dl_wr_i),
		.dl_data_i   (dl_data_i),
		.load_port   (load_port),
		.cart_size_o (cart_size)
	);

	cart_bank_map u_bank_map (
		.cart_addr_i   (cart_addr_i),
		.cart_bs0_i    (cart_bs0_i),
		.cart_bs1_i    (cart_bs1_i),
		.cart_psen_n_i (cart_psen_n_i),
		.cart_size_i   (cart_size),
		.read_port     (read_port)
	);

	rom_arbiter u_arbiter (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_active_i (dl_active_i),
		.load_port   (load_port),
		.read_port   (read_port),
		.cart_data_o (cart_data_o)
	);

	////////////////////////////////
	// Keyboard and video
	////////////////////////////////
	key_translator u_keys (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.key_event_i    (key_event_i),
		.joy_numpad_i   (joy_numpad_i),
		.kbd_ready_o    (kbd_ready_o),
		.kbd_ascii_o    (kbd_ascii_o),
		.kbd_released_o (kbd_released_o)
	);

	palette_lut u_palette (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.is_pal_i (is_pal_i),
		.colour_i (colour_code),
		.rgb_o    (rgb_o)
	);

endmodule

`default_nettype wire

/* test/vp_glue_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module vp_glue_sva (
	input wire logic clk_sys,
	input wire logic reset,
	input wire logic is_pal_i,
	input wire logic dl_active_i,
	input wire logic psen_n_i,
	input wire logic cpu_en_i,
	input wire logic vdc_en_i,
	input wire logic [7:0] cart_data_i,
	input wire logic kbd_ready_i
);

	int fail_count = 0;
	logic [1:0] en;

	assign en = {vdc_en_i, cpu_en_i};

	// Channel 0 is the CPU enable, channel 1 the VDC enable
	for (genvar i = 0; i < 2; i++) begin : g_period
		logic [4:0] gap;
		logic pal_ref;
		logic mixed;
		logic [4:0] period;
		logic [4:0] longest;

		// Cycles since last pulse, and whether the standard moved inside it
		always_ff @(posedge clk_sys or posedge reset) begin
			if (reset) begin
				gap <= '0;
				pal_ref <= 1'b0;
				mixed <= 1'b1;
			end else if (en[i]) begin
				gap <= 5'd1;
				pal_ref <= is_pal_i;
				mixed <= 1'b0;
			end else begin
				gap <= gap + 1'b1;
				if (is_pal_i != pal_ref) begin
					mixed <= 1'b1;
				end
			end
		end

		assign period = (i == 0) ? (pal_ref ? 5'd12 : 5'd8) : (pal_ref ? 5'd10 : 5'd6);
		assign longest = (i == 0) ? 5'd12 : 5'd10;

		period_exact: assert property (@(posedge clk_sys) disable iff (reset)
			(en[i] && !mixed) |-> gap == period)
			else begin fail_count++; $error("Enable %0d period wrong", i); end
		period_bound: assert property (@(posedge clk_sys) disable iff (reset) gap <= longest)
			else begin fail_count++; $error("Enable %0d pulse missing", i); end
	end

	// Quiet during reset and in the first cycle after it
	enables_low_in_reset: assert property (@(posedge clk_sys)
		$past(reset) |-> !cpu_en_i && !vdc_en_i)
		else begin fail_count++; $error("Enable pulse around reset"); end

	// Open bus after an idle strobe or a download cycle
	idle_slot_empty: assert property (@(posedge clk_sys) disable iff (reset)
		(psen_n_i || dl_active_i) |=> cart_data_i == 8'hFF)
		else begin fail_count++; $error("Cartridge data not open bus"); end

	ready_one_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		kbd_ready_i |=> !kbd_ready_i)
		else begin fail_count++; $error("Keyboard ready longer than one cycle"); end

endmodule

bind vp_glue_top vp_glue_sva u_sva (
	.clk_sys(clk_sys), .reset(reset), .is_pal_i(is_pal_i), .dl_active_i(dl_active_i),
	.psen_n_i(cart_psen_n_i), .cpu_en_i(cpu_en_o), .vdc_en_i(vdc_en_o),
	.cart_data_i(cart_data_o), .kbd_ready_i(kbd_ready_o)
);

`default_nettype wire

/* test/vp_glue_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module vp_glue_tb;

	logic clk_sys, reset, is_pal_i, dl_active_i, dl_wr_i;
	logic [7:0] dl_data_i;
	logic [11:0] cart_addr_i;
	logic cart_bs0_i, cart_bs1_i, cart_psen_n_i;
	vp_pkg::key_event_t key_event_i;
	logic [9:0] joy_numpad_i;
	logic [3:0] colour_i;
	logic cpu_en_o, vdc_en_o, kbd_ready_o, kbd_released_o;
	logic [7:0] cart_data_o, kbd_ascii_o;
	logic [23:0] rgb_o;

	logic [7:0] model_rom [8192];
	logic [15:0] lfsr_state = 16'd4766;
	int loaded_size = 0;
	int errors = 0;
	int cycles = 0;

	vp_glue_top UUT (.*);

	always #20 clk_sys = ~clk_sys;

	// Cycle limit well above both downloads plus reads and key traffic
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= 25000) begin
			$display("Timeout: run did not finish within 25000 cycles");
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		if (state[0]) begin
			return (state >> 1) ^ 16'hB400;
		end
		return state >> 1;
	endfunction

	// One LFSR step per bit taken
	function automatic logic [15:0] rand_bits(input int count);
		logic [15:0] value;
		value = '0;
		for (int k = 0; k < count; k++) begin
			value = {value[14:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return value;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			errors++;
			$display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	// Download with psen held low so the slot reads as open bus
	task automatic download(input int count);
		logic [7:0] data;
		for (int i = 0; i < count; i++) begin
			data = 8'(rand_bits(8));
			model_rom[i] = data;
			dl_active_i <= 1'b1;
			dl_wr_i <= 1'b1;
			dl_data_i <= data;
			cart_psen_n_i <= 1'b0;
			@(negedge clk_sys);
			if (i % 1024 == 5) begin
				check_value("read_in_download", 8'hFF, cart_data_o);
			end
			@(posedge clk_sys);
		end
		dl_active_i <= 1'b0;
		dl_wr_i <= 1'b0;
		loaded_size = count;
	endtask

	task automatic read_check(input logic [11:0] addr, input logic bs0, input logic bs1);
		logic [12:0] rom_addr;
		cart_addr_i <= addr;
		cart_bs0_i <= bs0;
		cart_bs1_i <= bs1;
		cart_psen_n_i <= 1'b0;
		// Bank lines gated by image size and address bit 10 dropped
		rom_addr = {bs1 & (loaded_size >= 8192), bs0 & (loaded_size >= 4096), addr[11], addr[9:0]};
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value($sformatf("cart_read %03h bs%0d%0d", addr, bs1, bs0),
			model_rom[rom_addr], cart_data_o);
		@(posedge clk_sys);
	endtask

	task automatic ready_check(input string name, input logic [7:0] ascii,
		input logic check_ascii, input logic released);
		logic seen;
		seen = 1'b0;
		for (int n = 0; n < 8 && !seen; n++) begin
			@(negedge clk_sys);
			seen = kbd_ready_o;
		end
		if (!seen) begin
			errors++;
			$display("%s: no keyboard ready pulse within 8 cycles", name);
		end
		if (check_ascii) begin
			check_value(name, ascii, kbd_ascii_o);
		end
		check_value({name, " released"}, released, kbd_released_o);
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic key_check(input logic [7:0] code, input logic pressed,
		input logic [7:0] ascii, input string name);
		key_event_i <= {~key_event_i.toggle, pressed, 1'b0, code};
		ready_check(name, ascii, 1'b1, ~pressed);
	endtask

	task automatic colour_check(input logic [3:0] code, input logic pal, input logic [23:0] rgb);
		colour_i <= code;
		is_pal_i <= pal;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value($sformatf("colour %0d pal %0d", code, pal), rgb, rgb_o);
		@(posedge clk_sys);
	endtask

	//////////////////////////////
	// Stimulus
	//////////////////////////////
	initial begin
		clk_sys = 1'b0;
		reset = 1'b1;
		{is_pal_i, dl_active_i, dl_wr_i, dl_data_i} = '0;
		{cart_addr_i, cart_bs0_i, cart_bs1_i} = '0;
		cart_psen_n_i = 1'b1;
		key_event_i = '0;
		joy_numpad_i = '0;
		colour_i = '0;
		repeat (5) @(posedge clk_sys);
		reset <= 1'b0;
		repeat (20) @(posedge clk_sys);

		// Small image ignores both bank lines and reads stay inside its 2048 bytes
		download(2048);
		repeat (16) read_check(12'(rand_bits(12)) & 12'h7FF, 1'b1, 1'b1);

		// Full image read with every bank combination
		download(8192);
		for (int b = 0; b < 4; b++) begin
			repeat (8) read_check(12'(rand_bits(12)), b[0], b[1]);
		end
		cart_psen_n_i <= 1'b1;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value("psen_high", 8'hFF, cart_data_o);
		@(posedge clk_sys);

		// Keyboard then numpad with the last key event left released
		key_check(8'h1C, 1'b1, 8'h61, "key_a");
		key_check(8'h2E, 1'b1, 8'h35, "key_5");
		key_check(8'h5A, 1'b1, 8'h0A, "key_enter");
		key_check(8'h07, 1'b1, 8'h00, "key_unlisted");
		key_check(8'h1C, 1'b0, 8'h61, "key_a_release");
		joy_numpad_i <= 10'h204;
		ready_check("numpad_3", 8'h33, 1'b1, 1'b0);
		joy_numpad_i <= '0;
		ready_check("numpad_release", 8'h00, 1'b0, 1'b1);

		colour_check(4'd0, 1'b0, 24'h000000);
		colour_check(4'd8, 1'b0, 24'h790000);
		colour_check(4'd15, 1'b0, 24'hFFFFFF);
		colour_check(4'd0, 1'b1, 24'h000000);
		colour_check(4'd8, 1'b1, 24'hB60000);
		colour_check(4'd15, 1'b1, 24'hFFFFFF);
		// Several PAL enable periods
		repeat (60) @(posedge clk_sys);

		$display("Value errors: %0d, assertion failures: %0d", errors, UUT.u_sva.fail_count);
		if (errors == 0 && UUT.u_sva.fail_count == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
logic/vp_pkg.sv
logic/rom_port_if.sv
logic/clock_enable_gen.sv
logic/cart_loader.sv
logic/cart_bank_map.sv
logic/rom_arbiter.sv
logic/key_translator.sv
logic/palette_lut.sv
logic/vp_glue_top.sv
test/vp_glue_sva.sv
test/vp_glue_tb.sv
